// File: rtl/ps2kbd_pkg.sv
/*
 * Shared definitions for the PS/2 keyboard receiver
 *   scan code and Amiga key types, keymap word layout,
 *   PS/2 prefix codes, hold-off timeout width, handoff FSM states
 */
`default_nettype none

package ps2kbd_pkg;

	// --------------------
	// data types
	// --------------------
	typedef logic [7:0]  scan_code_t;    // one byte from the keyboard
	typedef logic [7:0]  amiga_key_t;    // key number plus upstroke flag
	typedef logic [15:0] keymap_entry_t; // one word of the keymap ROM

	// --------------------
	// PS/2 framing and codes
	// --------------------
	localparam int PS2_FRAME_BITS = 11; // start, 8 data, parity, stop

	localparam scan_code_t SCAN_EXTENDED = 8'hE0;
	localparam scan_code_t SCAN_RELEASE  = 8'hF0;
	localparam scan_code_t SCAN_ACK      = 8'hFA; // keyboard answer to a command

	// upstroke flag inside amiga_key_t, key number sits below it
	localparam int UPSTROKE_BIT = 7;

	// --------------------
	// keymap word layout
	// --------------------
	// bits 6..0 carry the Amiga key number of a mapped key
	localparam int KM_VALID  = 15; // mapped key, produces an event
	localparam int KM_CTRL   = 14;
	localparam int KM_LALT   = 13;
	localparam int KM_RALT   = 12;
	localparam int KM_CAPS   = 11;
	localparam int KM_PREFIX = 7;  // PS/2 protocol byte, never a key

	// prefix kind, only meaningful with KM_PREFIX set
	localparam int KM_PFX_EXT = 0;
	localparam int KM_PFX_REL = 1;
	localparam int KM_PFX_ACK = 2;

	// --------------------
	// host handoff
	// --------------------
	// keyboard is released at the latest when this counter wraps
	localparam int HOLD_TIMEOUT_BITS = 16;

	typedef enum logic
	{
		WAIT_KEY,
		HOLD
	} handoff_state_t;

endpackage

`default_nettype wire

// File: rtl/ps2_frame_rx.sv
/*
 * PS/2 frame receiver
 *   line synchronizers, falling clock edge detect,
 *   11-bit shifter with start bit marker
 */
`default_nettype none

module ps2_frame_rx
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	output logic       frame_valid,
	output scan_code_t frame_code
);

	logic [1:0]                clk_sync;
	logic [1:0]                dat_sync;
	logic                      clk_last; // previous synced clock level
	logic                      clk_fall;
	logic [PS2_FRAME_BITS-1:0] shreg;

	// two flops per line, clock side also keeps one older sample
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_sync <= 2'b11; // idle lines float high
			clk_last <= 1'b1;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk_in};
			clk_last <= clk_sync[1];
		end
	end

	always_ff @(posedge clk)
		dat_sync <= {dat_sync[0], ps2_dat_in};

	assign clk_fall = clk_last & ~clk_sync[1];

	// shift in from the top, the start bit ends up at bit 0
	always_ff @(posedge clk)
	begin
		if (reset || frame_valid)
			shreg <= '1;
		else if (clk_fall)
			shreg <= {dat_sync[1], shreg[PS2_FRAME_BITS-1:1]};
	end

	assign frame_valid = ~shreg[0]; // start bit arrived, frame complete
	assign frame_code  = shreg[$bits(scan_code_t):1];

endmodule

`default_nettype wire

// File: rtl/scan_decoder.sv
/*
 * Scan Code Set 2 to Amiga raw key decoder
 *   registered keymap ROM indexed by extended flag and scan code,
 *   E0 / F0 prefix tracking, modifier flag outputs
 */
`default_nettype none

module scan_decoder
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       frame_valid,
	input  scan_code_t frame_code,
	output logic       code_valid,
	output logic       is_ctrl_caps,
	output logic       is_lalt,
	output logic       is_ralt,
	output logic       is_caps,
	output amiga_key_t amiga_key
);

	keymap_entry_t rom_word;
	logic          rom_ready; // rom_word holds a fresh lookup
	logic          ext_flag;
	logic          rel_flag;
	logic          is_prefix;

	// keymap word for a plain mapped key
	function automatic keymap_entry_t km_key(input logic [UPSTROKE_BIT-1:0] num);
		km_key = '0;
		km_key[KM_VALID] = 1'b1;
		km_key[UPSTROKE_BIT-1:0] = num;
	endfunction

	// single flag bit, or'ed onto entries
	function automatic keymap_entry_t km_flag(input int unsigned pos);
		km_flag = '0;
		km_flag[pos] = 1'b1;
	endfunction

	// --------------------
	// keymap ROM
	// --------------------
	always_ff @(posedge clk)
	begin
		if (frame_valid)
		begin
			case ({ext_flag, frame_code})
				9'h015: rom_word <= km_key(7'h10); // q
				9'h01D: rom_word <= km_key(7'h11); // w
				9'h024: rom_word <= km_key(7'h12); // e
				9'h02D: rom_word <= km_key(7'h13); // r
				9'h02C: rom_word <= km_key(7'h14); // t
				9'h035: rom_word <= km_key(7'h15); // y
				9'h03C: rom_word <= km_key(7'h16); // u
				9'h043: rom_word <= km_key(7'h17); // i
				9'h044: rom_word <= km_key(7'h18); // o
				9'h04D: rom_word <= km_key(7'h19); // p
				9'h01C: rom_word <= km_key(7'h20); // a
				9'h01B: rom_word <= km_key(7'h21); // s
				9'h023: rom_word <= km_key(7'h22); // d
				9'h02B: rom_word <= km_key(7'h23); // f
				9'h034: rom_word <= km_key(7'h24); // g
				9'h033: rom_word <= km_key(7'h25); // h
				9'h03B: rom_word <= km_key(7'h26); // j
				9'h042: rom_word <= km_key(7'h27); // k
				9'h04B: rom_word <= km_key(7'h28); // l
				9'h01A: rom_word <= km_key(7'h31); // z
				9'h022: rom_word <= km_key(7'h32); // x
				9'h021: rom_word <= km_key(7'h33); // c
				9'h02A: rom_word <= km_key(7'h34); // v
				9'h032: rom_word <= km_key(7'h35); // b
				9'h031: rom_word <= km_key(7'h36); // n
				9'h03A: rom_word <= km_key(7'h37); // m
				9'h016: rom_word <= km_key(7'h01); // 1
				9'h01E: rom_word <= km_key(7'h02); // 2
				9'h026: rom_word <= km_key(7'h03); // 3
				9'h025: rom_word <= km_key(7'h04); // 4
				9'h02E: rom_word <= km_key(7'h05); // 5
				9'h036: rom_word <= km_key(7'h06); // 6
				9'h03D: rom_word <= km_key(7'h07); // 7
				9'h03E: rom_word <= km_key(7'h08); // 8
				9'h046: rom_word <= km_key(7'h09); // 9
				9'h045: rom_word <= km_key(7'h0A); // 0
				9'h029: rom_word <= km_key(7'h40); // space
				9'h05A: rom_word <= km_key(7'h44); // enter
				9'h066: rom_word <= km_key(7'h41); // backspace
				9'h076: rom_word <= km_key(7'h45); // escape
				9'h012: rom_word <= km_key(7'h60); // left shift
				9'h059: rom_word <= km_key(7'h61); // right shift
				9'h058: rom_word <= km_key(7'h62) | km_flag(KM_CAPS);
				9'h014: rom_word <= km_key(7'h63) | km_flag(KM_CTRL);
				9'h011: rom_word <= km_key(7'h64) | km_flag(KM_LALT);
				9'h111: rom_word <= km_key(7'h65) | km_flag(KM_RALT);
				9'h175: rom_word <= km_key(7'h4C); // arrow up
				9'h172: rom_word <= km_key(7'h4D); // arrow down
				9'h174: rom_word <= km_key(7'h4E); // arrow right
				9'h16B: rom_word <= km_key(7'h4F); // arrow left
				// protocol bytes decode the same with or without E0 before them
				{1'b0, SCAN_EXTENDED}, {1'b1, SCAN_EXTENDED}:
					rom_word <= km_flag(KM_PREFIX) | km_flag(KM_PFX_EXT);
				{1'b0, SCAN_RELEASE}, {1'b1, SCAN_RELEASE}:
					rom_word <= km_flag(KM_PREFIX) | km_flag(KM_PFX_REL);
				{1'b0, SCAN_ACK}, {1'b1, SCAN_ACK}:
					rom_word <= km_flag(KM_PREFIX) | km_flag(KM_PFX_ACK);
				default: rom_word <= '0; // unmapped
			endcase
		end
	end

	// ROM output is valid one cycle after the lookup
	always_ff @(posedge clk)
	begin
		if (reset)
			rom_ready <= 1'b0;
		else
			rom_ready <= frame_valid;
	end

	assign is_prefix = rom_word[KM_PREFIX];

	// --------------------
	// prefix tracking
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ext_flag <= 1'b0;
			rel_flag <= 1'b0;
		end
		else if (rom_ready)
		begin
			if (is_prefix && rom_word[KM_PFX_EXT])
				ext_flag <= 1'b1;
			else if (is_prefix && rom_word[KM_PFX_REL])
				rel_flag <= 1'b1;
			else if (!(is_prefix && rom_word[KM_PFX_ACK])) // ack leaves both alone
			begin
				ext_flag <= 1'b0;
				rel_flag <= 1'b0;
			end
		end
	end

	assign code_valid   = rom_ready & rom_word[KM_VALID];
	assign is_ctrl_caps = rom_word[KM_CTRL] | rom_word[KM_CAPS];
	assign is_lalt      = rom_word[KM_LALT];
	assign is_ralt      = rom_word[KM_RALT];
	assign is_caps      = rom_word[KM_CAPS];
	assign amiga_key    = {rel_flag, rom_word[UPSTROKE_BIT-1:0]};

endmodule

`default_nettype wire

// File: rtl/key_state_tracker.sv
/*
 * Key state tracker
 *   typematic duplicate filter, Amiga style caps lock latch,
 *   ctrl / left alt / right alt reset combination detector
 */
`default_nettype none

module key_state_tracker
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       code_valid,
	input  logic       is_ctrl_caps,
	input  logic       is_lalt,
	input  logic       is_ralt,
	input  logic       is_caps,
	input  amiga_key_t amiga_key,
	output logic       key_strobe,
	output logic       caps_lock,
	output logic       kbd_reset
);

	amiga_key_t last_key; // last downstroke, or its matching upstroke
	logic       upstroke;
	logic       key_equal;
	logic       dup_event;
	logic [2:0] held;     // ctrl or caps, left alt, right alt

	assign upstroke  = amiga_key[UPSTROKE_BIT];
	assign key_equal = last_key[UPSTROKE_BIT-1:0] == amiga_key[UPSTROKE_BIT-1:0];
	assign dup_event = key_equal && (last_key[UPSTROKE_BIT] == upstroke);

	// --------------------
	// duplicate filter
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			last_key <= '0;
		else if (code_valid && !upstroke)
			last_key <= amiga_key;
		else if (code_valid && upstroke && key_equal) // release of the latched key
			last_key <= amiga_key;
	end

	// caps lock flips on a fresh caps downstroke only
	always_ff @(posedge clk)
	begin
		if (reset)
			caps_lock <= 1'b0;
		else if (code_valid && !upstroke && is_caps && !dup_event)
			caps_lock <= ~caps_lock;
	end

	// while latched on, the host sees no caps events at all
	always_comb
	begin
		if (caps_lock && is_caps)
			key_strobe = 1'b0;
		else if (dup_event)
			key_strobe = 1'b0;
		else
			key_strobe = code_valid;
	end

	// --------------------
	// reset combination
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			held <= 3'b000;
		else if (code_valid)
		begin
			if (is_ctrl_caps)
				held[2] <= ~upstroke;
			if (is_lalt)
				held[1] <= ~upstroke;
			if (is_ralt)
				held[0] <= ~upstroke;
		end
	end

	assign kbd_reset = &held; // all three keys down

endmodule

`default_nettype wire

// File: rtl/host_handoff.sv
/*
 * Host handoff
 *   holds the keyboard off after every delivered key
 *   until the host acknowledges or the hold counter wraps
 */
`default_nettype none

module host_handoff
	import ps2kbd_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic key_strobe,
	input  logic key_ack,
	output logic clk_inhibit
);

	handoff_state_t                 state;
	handoff_state_t                 state_next;
	logic [HOLD_TIMEOUT_BITS-1:0]   hold_count;
	logic                           hold_expired;

	assign hold_expired = &hold_count; // last cycle before wrap

	// --------------------
	// FSM
	// --------------------
	always_comb
	begin
		state_next = state;
		case (state)
			WAIT_KEY:
				if (key_strobe)
					state_next = HOLD;
			HOLD:
				if (key_ack || hold_expired)
					state_next = WAIT_KEY;
			default:
				state_next = WAIT_KEY;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= WAIT_KEY;
		else
			state <= state_next;
	end

	// counts only inside HOLD, so each hold starts from zero
	always_ff @(posedge clk)
	begin
		if (reset || state != HOLD)
			hold_count <= '0;
		else
			hold_count <= hold_count + 1'b1;
	end

	assign clk_inhibit = (state == HOLD);

endmodule

`default_nettype wire

// File: rtl/ps2_keyboard.sv
/*
 * PS/2 keyboard receiver top level
 *   frame receiver, scan decoder, key state tracker, host handoff,
 *   open-collector drive of the PS/2 lines
 */
`default_nettype none

module ps2_keyboard
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       key_ack,
	inout  wire        ps2_kclk,
	inout  wire        ps2_kdat,
	output logic       key_strobe,
	output logic       caps_lock,
	output logic       kbd_reset,
	output amiga_key_t key_data
);

	logic       frame_valid;
	scan_code_t frame_code;
	logic       code_valid;
	logic       is_ctrl_caps;
	logic       is_lalt;
	logic       is_ralt;
	logic       is_caps;
	logic       clk_inhibit;

	// only ever pull low or let go, pull-ups are on the board
	assign ps2_kclk = clk_inhibit ? 1'b0 : 1'bz;
	assign ps2_kdat = 1'bz; // receive only

	// --------------------
	// stages
	// --------------------
	ps2_frame_rx frame_rx0 (
		.clk         (clk),
		.reset       (reset),
		.ps2_clk_in  (ps2_kclk),
		.ps2_dat_in  (ps2_kdat),
		.frame_valid (frame_valid),
		.frame_code  (frame_code)
	);

	scan_decoder decoder0 (
		.clk          (clk),
		.reset        (reset),
		.frame_valid  (frame_valid),
		.frame_code   (frame_code),
		.code_valid   (code_valid),
		.is_ctrl_caps (is_ctrl_caps),
		.is_lalt      (is_lalt),
		.is_ralt      (is_ralt),
		.is_caps      (is_caps),
		.amiga_key    (key_data)
	);

	key_state_tracker tracker0 (
		.clk          (clk),
		.reset        (reset),
		.code_valid   (code_valid),
		.is_ctrl_caps (is_ctrl_caps),
		.is_lalt      (is_lalt),
		.is_ralt      (is_ralt),
		.is_caps      (is_caps),
		.amiga_key    (key_data),
		.key_strobe   (key_strobe),
		.caps_lock    (caps_lock),
		.kbd_reset    (kbd_reset)
	);

	host_handoff handoff0 (
		.clk         (clk),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_ack     (key_ack),
		.clk_inhibit (clk_inhibit)
	);

endmodule

`default_nettype wire

// File: tb/tb_ps2_keyboard.sv
/*
 * Testbench for the PS/2 keyboard receiver
 *   open-collector keyboard model, reference keymap,
 *   host ack responder, strobe monitor, directed tests
 */
`default_nettype none

module tb_ps2_keyboard
	import ps2kbd_pkg::*;
();

	localparam int WAIT_LIMIT = 2000; // cycles allowed for a strobe or a line release

	logic       clk = 1'b0;
	logic       reset = 1'b1;
	logic       key_ack = 1'b0;
	logic       kbd_clk_drv = 1'b1; // keyboard drive where 0 pulls the line low
	logic       kbd_dat_drv = 1'b1;
	wire        ps2_kclk;
	wire        ps2_kdat;
	logic       key_strobe;
	logic       caps_lock;
	logic       kbd_reset;
	amiga_key_t key_data;
	amiga_key_t strobe_q[$];    // keys seen by the monitor
	int         ack_delay = 3;  // 0 withholds key_ack
	int         ack_count = 0;

	pullup (ps2_kclk);
	pullup (ps2_kdat);
	assign ps2_kclk = kbd_clk_drv ? 1'bz : 1'b0;
	assign ps2_kdat = kbd_dat_drv ? 1'bz : 1'b0;

	ps2_keyboard dut0 (
		.clk        (clk),
		.reset      (reset),
		.key_ack    (key_ack),
		.ps2_kclk   (ps2_kclk),
		.ps2_kdat   (ps2_kdat),
		.key_strobe (key_strobe),
		.caps_lock  (caps_lock),
		.kbd_reset  (kbd_reset),
		.key_data   (key_data)
	);

	always #5 clk = ~clk;

	// host model pulses key_ack ack_delay cycles after each strobe
	always @(posedge clk)
	begin
		key_ack <= 1'b0;
		if (reset)
			ack_count <= 0;
		else if (key_strobe && ack_delay != 0)
			ack_count <= ack_delay;
		else if (ack_count != 0)
		begin
			ack_count <= ack_count - 1;
			key_ack <= (ack_count == 1);
		end
	end

	always @(posedge clk)
		if (!reset && key_strobe)
			strobe_q.push_back(key_data);

	// --------------------
	// checking helpers
	// --------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		assert (got === expected)
		else
			report_failure($sformatf("mismatch %s: expected 0x%h, got 0x%h", name, expected, got));
	endtask

	// reference keymap for the keys the tests use
	function automatic amiga_key_t amiga_code_of(input logic ext, input scan_code_t scan,
			input logic released);
		logic [6:0] num;
		case ({ext, scan})
			9'h01C: num = 7'h20; // a
			9'h01B: num = 7'h21; // s
			9'h058: num = 7'h62; // caps
			9'h014: num = 7'h63; // ctrl
			9'h011: num = 7'h64; // left alt
			9'h111: num = 7'h65; // right alt
			9'h175: num = 7'h4C; // up arrow
			default: num = 7'h7F;
		endcase
		return {released, num};
	endfunction

	task automatic expect_key(input amiga_key_t expected);
		int n;
		amiga_key_t got;
		n = 0;
		while (strobe_q.size() == 0 && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		assert (strobe_q.size() != 0)
		else
			report_failure($sformatf("no key_strobe seen, expected key 0x%h", expected));
		got = strobe_q.pop_front();
		assert (got == expected)
		else
			report_failure($sformatf("mismatch key_data: expected 0x%h, got 0x%h", expected, got));
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) @(negedge clk);
		assert (strobe_q.size() == 0)
		else
			report_failure($sformatf("unexpected key_strobe with key_data 0x%h", strobe_q[0]));
	endtask

	task automatic check_reset_outputs();
		check_bit("key_strobe", key_strobe, 1'b0);
		check_bit("caps_lock", caps_lock, 1'b0);
		check_bit("kbd_reset", kbd_reset, 1'b0);
		check_bit("ps2_kclk", ps2_kclk, 1'b1); // no hold-off yet
	endtask

	// --------------------
	// keyboard model
	// --------------------
	task automatic wait_clock_released(input int limit);
		int n;
		n = 0;
		while (ps2_kclk !== 1'b1 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		assert (ps2_kclk === 1'b1)
		else
			report_failure("PS/2 clock line not released by the DUT in time");
	endtask

	task automatic send_frame(input scan_code_t code);
		logic [PS2_FRAME_BITS-1:0] bits;
		bits = {1'b1, ~^code, code, 1'b0}; // stop, odd parity, data, start
		wait_clock_released(WAIT_LIMIT);
		for (int i = 0; i < PS2_FRAME_BITS; i++)
		begin
			@(posedge clk);
			kbd_dat_drv <= bits[i]; // data moves while the clock is high
			repeat (2) @(posedge clk);
			kbd_clk_drv <= 1'b0;
			repeat (4) @(posedge clk);
			kbd_clk_drv <= 1'b1;
			@(posedge clk);
		end
		kbd_dat_drv <= 1'b1;
		repeat (12) @(negedge clk); // idle gap
	endtask

	task automatic key_down(input logic ext, input scan_code_t scan);
		if (ext)
			send_frame(SCAN_EXTENDED);
		send_frame(scan);
	endtask

	task automatic key_up(input logic ext, input scan_code_t scan);
		if (ext)
			send_frame(SCAN_EXTENDED);
		send_frame(SCAN_RELEASE);
		send_frame(scan);
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic make_and_break();
		key_down(0, 8'h1C);
		expect_key(amiga_code_of(0, 8'h1C, 0));
		key_up(0, 8'h1C);
		expect_key(amiga_code_of(0, 8'h1C, 1));
	endtask

	task automatic typematic_filter();
		repeat (3) key_down(0, 8'h1C);
		key_up(0, 8'h1C);
		expect_key(amiga_code_of(0, 8'h1C, 0));
		expect_key(amiga_code_of(0, 8'h1C, 1));
		key_down(0, 8'h02); // unmapped
		expect_quiet(200);
	endtask

	task automatic extended_keys();
		key_down(1, 8'h75);
		expect_key(amiga_code_of(1, 8'h75, 0));
		key_up(1, 8'h75);
		expect_key(amiga_code_of(1, 8'h75, 1));
		// an ack byte between E0 and the code keeps the extended flag
		send_frame(SCAN_EXTENDED);
		send_frame(SCAN_ACK);
		send_frame(8'h75);
		expect_key(amiga_code_of(1, 8'h75, 0));
		key_down(0, 8'h1C); // prefix flags must be clear again
		expect_key(amiga_code_of(0, 8'h1C, 0));
	endtask

	task automatic caps_latch();
		key_down(0, 8'h58);
		expect_key(amiga_code_of(0, 8'h58, 0));
		check_bit("caps_lock", caps_lock, 1'b1);
		key_up(0, 8'h58);
		key_down(0, 8'h58);
		check_bit("caps_lock", caps_lock, 1'b0);
		key_up(0, 8'h58);
		expect_key(amiga_code_of(0, 8'h58, 1));
		expect_quiet(50);
	endtask

	task automatic reset_combination();
		key_down(0, 8'h14);
		key_down(0, 8'h11);
		check_bit("kbd_reset", kbd_reset, 1'b0);
		key_down(1, 8'h11);
		check_bit("kbd_reset", kbd_reset, 1'b1); // all three held
		key_up(0, 8'h11);
		check_bit("kbd_reset", kbd_reset, 1'b0);
		expect_key(amiga_code_of(0, 8'h14, 0));
		expect_key(amiga_code_of(0, 8'h11, 0));
		expect_key(amiga_code_of(1, 8'h11, 0));
		expect_key(amiga_code_of(0, 8'h11, 1));
	endtask

	task automatic keyboard_hold_off();
		int n;
		ack_delay = 20; // late ack leaves time to see the held clock
		key_down(0, 8'h1B);
		expect_key(amiga_code_of(0, 8'h1B, 0));
		n = 0;
		while (key_ack !== 1'b1 && n < WAIT_LIMIT)
		begin
			check_bit("ps2_kclk", ps2_kclk, 1'b0); // held until the ack
			@(negedge clk);
			n++;
		end
		assert (key_ack === 1'b1)
		else
			report_failure("host model never raised key_ack");
		wait_clock_released(4);
		// without any ack only the hold counter ends it
		ack_delay = 0;
		key_up(0, 8'h1B);
		expect_key(amiga_code_of(0, 8'h1B, 1));
		check_bit("ps2_kclk", ps2_kclk, 1'b0);
		n = 0;
		while (ps2_kclk !== 1'b1 && n < 2 ** HOLD_TIMEOUT_BITS + 64)
		begin
			@(negedge clk);
			n++;
		end
		assert (ps2_kclk === 1'b1)
		else
			report_failure("PS/2 clock still held after the hold timeout");
		assert (n >= 2 ** HOLD_TIMEOUT_BITS - 64)
		else
			report_failure("hold released early without key_ack");
		ack_delay = 3;
	endtask

	initial
	begin
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_reset_outputs();
		make_and_break();
		typematic_filter();
		extended_keys();
		caps_latch();
		reset_combination();
		keyboard_hold_off();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
rtl/ps2kbd_pkg.sv
rtl/ps2_frame_rx.sv
rtl/scan_decoder.sv
rtl/key_state_tracker.sv
rtl/host_handoff.sv
rtl/ps2_keyboard.sv
tb/tb_ps2_keyboard.sv

// File: Bender.yml
package:
  name: ps2_keyboard

sources:
  - rtl/ps2kbd_pkg.sv
  - rtl/ps2_frame_rx.sv
  - rtl/scan_decoder.sv
  - rtl/key_state_tracker.sv
  - rtl/host_handoff.sv
  - rtl/ps2_keyboard.sv
  - target: test
    files:
      - tb/tb_ps2_keyboard.sv
